// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // memory opcode from the execute stage
   typedef logic [3:0] lsu_op_t;

   localparam lsu_op_t LSU_LD_B  = 4'h0;
   localparam lsu_op_t LSU_LD_H  = 4'h1;
   localparam lsu_op_t LSU_LD_W  = 4'h2;
   localparam lsu_op_t LSU_LD_BU = 4'h4;
   localparam lsu_op_t LSU_LD_HU = 4'h5;
   localparam lsu_op_t LSU_ST_B  = 4'h8;
   localparam lsu_op_t LSU_ST_H  = 4'h9;
   localparam lsu_op_t LSU_ST_W  = 4'ha;
   localparam lsu_op_t LSU_LL_W  = 4'hc;
   localparam lsu_op_t LSU_SC_W  = 4'he;

   // register and bus data word
   typedef logic [31:0] word_t;

   // one strobe per byte lane
   typedef logic [3:0] strb_t;

   // byte position inside a word
   typedef logic [1:0] byte_off_t;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   // outstanding request tracker
   typedef enum logic {
      TRK_IDLE      = 1'b0,
      TRK_WAIT_DATA = 1'b1
   } track_state_e;

endpackage

`default_nettype wire

// ==== design/lsu_issue.sv ====
`default_nettype none

module lsu_issue import lsu_pkg::*; (
   input  wire logic    clk,
   input  wire logic    rst_n,
   input  wire logic    valid,
   input  wire lsu_op_t lsu_op,
   input  wire word_t   base,
   input  wire word_t   offset,
   input  wire word_t   wdata,

   output logic         data_req,
   output word_t        data_addr,
   output logic         data_wr,
   output strb_t        data_wstrb,
   output word_t        data_wdata,
   output logic         data_ll,
   output logic         data_sc,

   output access_size_e ld_size,
   output logic         ld_unsigned,
   output logic         is_sc,
   output byte_off_t    addr_off
);

   access_size_e size;
   logic         is_store;
   logic         is_ll;
   logic         is_unsigned;
   logic         sc_op;
   word_t        addr;
   strb_t        strb_base;

   // single decode of the opcode, shared by request and load fields
   always_comb begin
      size        = SIZE_WORD;
      is_store    = 1'b0;
      is_ll       = 1'b0;
      is_unsigned = 1'b0;
      sc_op       = 1'b0;
      case (lsu_op)
         LSU_LD_B:  size = SIZE_BYTE;
         LSU_LD_H:  size = SIZE_HALF;
         LSU_LD_W:  size = SIZE_WORD;
         LSU_LD_BU: begin
            size        = SIZE_BYTE;
            is_unsigned = 1'b1;
         end
         LSU_LD_HU: begin
            size        = SIZE_HALF;
            is_unsigned = 1'b1;
         end
         LSU_ST_B: begin
            size     = SIZE_BYTE;
            is_store = 1'b1;
         end
         LSU_ST_H: begin
            size     = SIZE_HALF;
            is_store = 1'b1;
         end
         LSU_ST_W:  is_store = 1'b1;
         LSU_LL_W:  is_ll = 1'b1;
         LSU_SC_W: begin
            is_store = 1'b1;
            sc_op    = 1'b1;
         end
         default: ;
      endcase
   end

   assign addr = base + offset;

   always_comb begin
      case (size)
         SIZE_BYTE: strb_base = 4'b0001;
         SIZE_HALF: strb_base = 4'b0011;
         default:   strb_base = 4'b1111;
      endcase
   end

   assign data_wstrb = is_store ? strb_t'(strb_base << addr[1:0]) : '0;

   // narrow store data goes out on every lane, the strobe picks the one written
   always_comb begin
      data_wdata = '0;
      if (is_store) begin
         case (size)
            SIZE_BYTE: data_wdata = {4{wdata[7:0]}};
            SIZE_HALF: data_wdata = {2{wdata[15:0]}};
            default:   data_wdata = wdata;
         endcase
      end
   end

   assign data_req    = valid;
   assign data_addr   = addr;
   assign data_wr     = is_store;
   assign data_ll     = is_ll;
   assign data_sc     = sc_op;

   assign ld_size     = size;
   assign ld_unsigned = is_unsigned;
   assign is_sc       = sc_op;
   assign addr_off    = addr[1:0];

   // the core only issues naturally aligned accesses
   a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      valid |-> !(size == SIZE_WORD && addr[1:0] != 2'b00) && !(size == SIZE_HALF && addr[0]))
      else $error("misaligned request addr=%h size=%s", addr, size.name());

endmodule

`default_nettype wire

// ==== design/lsu_mem_track.sv ====
`default_nettype none

module lsu_mem_track import lsu_pkg::*; #(
   parameter int REG_ADDR_W = 5
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic                  valid,
   input  wire access_size_e          ld_size,
   input  wire logic                  ld_unsigned,
   input  wire logic                  is_sc,
   input  wire byte_off_t             addr_off,
   input  wire logic [REG_ADDR_W-1:0] ecl_lsu_rd_e,
   input  wire logic                  ecl_lsu_wen_e,
   input  wire logic                  data_addr_ok,
   input  wire logic                  data_data_ok,

   output access_size_e               size_m,
   output logic                       unsigned_m,
   output logic                       sc_m,
   output byte_off_t                  off_m,
   output logic [REG_ADDR_W-1:0]      lsu_ecl_rd_m,
   output logic                       lsu_ecl_wen_m,
   output logic                       data_recv
);

   track_state_e state;
   track_state_e state_next;

   // execute to memory register, refreshed while the core holds valid
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         size_m        <= SIZE_WORD;
         unsigned_m    <= 1'b0;
         sc_m          <= 1'b0;
         off_m         <= '0;
         lsu_ecl_rd_m  <= '0;
         lsu_ecl_wen_m <= 1'b0;
      end else if (valid) begin
         size_m        <= ld_size;
         unsigned_m    <= ld_unsigned;
         sc_m          <= is_sc;
         off_m         <= addr_off;
         lsu_ecl_rd_m  <= ecl_lsu_rd_e;
         lsu_ecl_wen_m <= ecl_lsu_wen_e;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         TRK_IDLE: begin
            // accept and return in one cycle leaves nothing outstanding
            if (data_addr_ok && !data_data_ok)
               state_next = TRK_WAIT_DATA;
         end
         TRK_WAIT_DATA: begin
            if (data_data_ok)
               state_next = TRK_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= TRK_IDLE;
      else
         state <= state_next;
   end

   assign data_recv = (state == TRK_WAIT_DATA);

   a_data_ok_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      (state == TRK_IDLE && data_data_ok) |-> data_addr_ok)
      else $error("data_data_ok with no request outstanding");

   a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      (state == TRK_WAIT_DATA) |-> !data_addr_ok)
      else $error("data_addr_ok while a request is outstanding");

endmodule

`default_nettype wire

// ==== design/lsu_load_align.sv ====
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
   input  wire logic         clk,
   input  wire logic         rst_n,
   input  wire word_t        data_rdata,
   input  wire logic         data_scsucceed,
   input  wire access_size_e size_m,
   input  wire logic         unsigned_m,
   input  wire logic         sc_m,
   input  wire byte_off_t    off_m,

   output word_t             read_result_m
);

   logic [7:0]  byte_lane;
   logic [15:0] half_lane;
   logic        byte_sign;
   logic        half_sign;

   // lane picked by the low address bits of the request
   assign byte_lane = data_rdata[{off_m, 3'b000} +: 8];
   assign half_lane = data_rdata[{off_m[1], 4'b0000} +: 16];

   assign byte_sign = byte_lane[7] & ~unsigned_m;
   assign half_sign = half_lane[15] & ~unsigned_m;

   always_comb begin
      if (sc_m) begin
         // sc writes back only its success flag
         read_result_m = {31'd0, data_scsucceed};
      end else begin
         case (size_m)
            SIZE_BYTE: read_result_m = {{24{byte_sign}}, byte_lane};
            SIZE_HALF: read_result_m = {{16{half_sign}}, half_lane};
            default:   read_result_m = data_rdata;
         endcase
      end
   end

   // alignment checked at issue must still hold on the registered offset
   a_half_even_offset: assert property (@(posedge clk) disable iff (!rst_n)
      (size_m == SIZE_HALF && !sc_m) |-> !off_m[0])
      else $error("halfword load with odd offset %h", off_m);

endmodule

`default_nettype wire

// ==== design/lsu_top.sv ====
`default_nettype none

module lsu_top import lsu_pkg::*; #(
   parameter int REG_ADDR_W = 5
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,

   // core side
   input  wire logic                  valid,
   input  wire lsu_op_t               lsu_op,
   input  wire word_t                 base,
   input  wire word_t                 offset,
   input  wire word_t                 wdata,
   input  wire logic [REG_ADDR_W-1:0] ecl_lsu_rd_e,
   input  wire logic                  ecl_lsu_wen_e,

   // data bus
   output logic                       data_req,
   output word_t                      data_addr,
   output logic                       data_wr,
   output strb_t                      data_wstrb,
   output word_t                      data_wdata,
   output logic                       data_ll,
   output logic                       data_sc,
   input  wire logic                  data_addr_ok,
   output logic                       data_recv,
   input  wire logic                  data_scsucceed,
   input  wire word_t                 data_rdata,
   input  wire logic                  data_data_ok,

   // memory stage result
   output word_t                      read_result_m,
   output logic                       lsu_rdata_valid_m,
   output logic [REG_ADDR_W-1:0]      lsu_ecl_rd_m,
   output logic                       lsu_ecl_wen_m
);

   access_size_e ld_size;
   logic         ld_unsigned;
   logic         is_sc;
   byte_off_t    addr_off;
   access_size_e size_m;
   logic         unsigned_m;
   logic         sc_m;
   byte_off_t    off_m;

   lsu_issue u_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .valid       (valid),
      .lsu_op      (lsu_op),
      .base        (base),
      .offset      (offset),
      .wdata       (wdata),
      .data_req    (data_req),
      .data_addr   (data_addr),
      .data_wr     (data_wr),
      .data_wstrb  (data_wstrb),
      .data_wdata  (data_wdata),
      .data_ll     (data_ll),
      .data_sc     (data_sc),
      .ld_size     (ld_size),
      .ld_unsigned (ld_unsigned),
      .is_sc       (is_sc),
      .addr_off    (addr_off)
   );

   lsu_mem_track #(
      .REG_ADDR_W (REG_ADDR_W)
   ) u_mem_track (
      .clk           (clk),
      .rst_n         (rst_n),
      .valid         (valid),
      .ld_size       (ld_size),
      .ld_unsigned   (ld_unsigned),
      .is_sc         (is_sc),
      .addr_off      (addr_off),
      .ecl_lsu_rd_e  (ecl_lsu_rd_e),
      .ecl_lsu_wen_e (ecl_lsu_wen_e),
      .data_addr_ok  (data_addr_ok),
      .data_data_ok  (data_data_ok),
      .size_m        (size_m),
      .unsigned_m    (unsigned_m),
      .sc_m          (sc_m),
      .off_m         (off_m),
      .lsu_ecl_rd_m  (lsu_ecl_rd_m),
      .lsu_ecl_wen_m (lsu_ecl_wen_m),
      .data_recv     (data_recv)
   );

   lsu_load_align u_load_align (
      .clk            (clk),
      .rst_n          (rst_n),
      .data_rdata     (data_rdata),
      .data_scsucceed (data_scsucceed),
      .size_m         (size_m),
      .unsigned_m     (unsigned_m),
      .sc_m           (sc_m),
      .off_m          (off_m),
      .read_result_m  (read_result_m)
   );

   // result is valid exactly when the bus returns data
   assign lsu_rdata_valid_m = data_data_ok;

endmodule

`default_nettype wire

// ==== verif/lsu_mem_model.sv ====
`default_nettype none

module lsu_mem_model import lsu_pkg::*; (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       data_req,
   input  wire word_t      data_addr,
   input  wire logic       data_wr,
   input  wire strb_t      data_wstrb,
   input  wire word_t      data_wdata,
   input  wire logic       data_ll,
   input  wire logic       data_sc,
   input  wire logic [1:0] accept_delay,
   input  wire logic [1:0] return_delay,

   output logic            data_addr_ok,
   output logic            data_data_ok,
   output word_t           data_rdata,
   output logic            data_scsucceed
);

   timeunit 1ns;
   timeprecision 1ps;

   typedef enum logic [1:0] {
      MEM_IDLE,
      MEM_ACCEPT,
      MEM_RETURN
   } mem_phase_e;

   word_t      mem [64];
   mem_phase_e phase;
   logic [1:0] count;
   logic       resv_valid;
   logic [5:0] resv_idx;
   word_t      rdata_hold;
   logic       sc_hold;

   always @(posedge clk or negedge rst_n) begin
      logic [5:0] idx;
      logic       sc_ok;
      logic [7:0] ba;
      if (!rst_n) begin
         for (int i = 0; i < 64; i++) begin
            ba = 8'(i << 2);
            mem[i] <= {ba ^ 8'h5a, ba ^ 8'hc3, ~ba, ba};
         end
         phase          <= MEM_IDLE;
         count          <= '0;
         resv_valid     <= 1'b0;
         resv_idx       <= '0;
         rdata_hold     <= '0;
         sc_hold        <= 1'b0;
         data_addr_ok   <= 1'b0;
         data_data_ok   <= 1'b0;
         data_rdata     <= '0;
         data_scsucceed <= 1'b0;
      end else begin
         data_addr_ok <= 1'b0;
         data_data_ok <= 1'b0;
         idx   = data_addr[7:2];
         sc_ok = data_sc && resv_valid && (resv_idx == idx);
         case (phase)
            MEM_IDLE: begin
               if (data_req) begin
                  phase <= MEM_ACCEPT;
                  count <= accept_delay;
               end
            end
            MEM_ACCEPT: begin
               if (count != 0) begin
                  count <= count - 2'd1;
               end else begin
                  // the access itself happens in the accept cycle
                  data_addr_ok <= 1'b1;
                  phase        <= MEM_RETURN;
                  count        <= return_delay;
                  rdata_hold   <= mem[idx];
                  sc_hold      <= sc_ok;
                  if (data_wr && (!data_sc || sc_ok)) begin
                     for (int i = 0; i < 4; i++) begin
                        if (data_wstrb[i])
                           mem[idx][8*i +: 8] <= data_wdata[8*i +: 8];
                     end
                  end
                  if (data_ll) begin
                     resv_valid <= 1'b1;
                     resv_idx   <= idx;
                  end else if (data_sc) begin
                     resv_valid <= 1'b0;
                  end else if (data_wr && idx == resv_idx) begin
                     resv_valid <= 1'b0;
                  end
               end
            end
            default: begin
               if (count != 0) begin
                  count <= count - 2'd1;
               end else begin
                  data_data_ok   <= 1'b1;
                  data_rdata     <= rdata_hold;
                  data_scsucceed <= sc_hold;
                  phase          <= MEM_IDLE;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_lsu.sv ====
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int REG_ADDR_W = 5;
   localparam int NUM_OPS    = 2000;
   localparam int WAIT_LIMIT = 32;

   localparam lsu_op_t OP_LIST [10] = '{LSU_LD_B, LSU_LD_H, LSU_LD_W, LSU_LD_BU, LSU_LD_HU,
                                        LSU_ST_B, LSU_ST_H, LSU_ST_W, LSU_LL_W, LSU_SC_W};

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  valid;
   lsu_op_t               lsu_op;
   word_t                 base;
   word_t                 offset;
   word_t                 wdata;
   logic [REG_ADDR_W-1:0] ecl_lsu_rd_e;
   logic                  ecl_lsu_wen_e;
   logic [1:0]            accept_delay;
   logic [1:0]            return_delay;

   logic                  data_req;
   word_t                 data_addr;
   logic                  data_wr;
   strb_t                 data_wstrb;
   word_t                 data_wdata;
   logic                  data_ll;
   logic                  data_sc;
   logic                  data_addr_ok;
   logic                  data_recv;
   logic                  data_scsucceed;
   word_t                 data_rdata;
   logic                  data_data_ok;
   word_t                 read_result_m;
   logic                  lsu_rdata_valid_m;
   logic [REG_ADDR_W-1:0] lsu_ecl_rd_m;
   logic                  lsu_ecl_wen_m;

   logic [31:0]           lfsr;
   word_t                 shadow [64];
   logic                  shadow_resv_valid;
   logic [5:0]            shadow_resv_idx;
   word_t                 exp_addr;
   logic [2:0]            exp_ctrl;
   strb_t                 exp_wstrb;
   word_t                 exp_wdata;
   word_t                 exp_result;
   logic                  exp_check_result;
   logic [REG_ADDR_W-1:0] exp_rd;
   logic                  exp_wen;
   logic                  outstanding;

   always #4 clk = ~clk;

   lsu_top #(
      .REG_ADDR_W (REG_ADDR_W)
   ) DUT (
      .clk               (clk),
      .rst_n             (rst_n),
      .valid             (valid),
      .lsu_op            (lsu_op),
      .base              (base),
      .offset            (offset),
      .wdata             (wdata),
      .ecl_lsu_rd_e      (ecl_lsu_rd_e),
      .ecl_lsu_wen_e     (ecl_lsu_wen_e),
      .data_req          (data_req),
      .data_addr         (data_addr),
      .data_wr           (data_wr),
      .data_wstrb        (data_wstrb),
      .data_wdata        (data_wdata),
      .data_ll           (data_ll),
      .data_sc           (data_sc),
      .data_addr_ok      (data_addr_ok),
      .data_recv         (data_recv),
      .data_scsucceed    (data_scsucceed),
      .data_rdata        (data_rdata),
      .data_data_ok      (data_data_ok),
      .read_result_m     (read_result_m),
      .lsu_rdata_valid_m (lsu_rdata_valid_m),
      .lsu_ecl_rd_m      (lsu_ecl_rd_m),
      .lsu_ecl_wen_m     (lsu_ecl_wen_m)
   );

   lsu_mem_model u_mem (
      .clk            (clk),
      .rst_n          (rst_n),
      .data_req       (data_req),
      .data_addr      (data_addr),
      .data_wr        (data_wr),
      .data_wstrb     (data_wstrb),
      .data_wdata     (data_wdata),
      .data_ll        (data_ll),
      .data_sc        (data_sc),
      .accept_delay   (accept_delay),
      .return_delay   (return_delay),
      .data_addr_ok   (data_addr_ok),
      .data_data_ok   (data_data_ok),
      .data_rdata     (data_rdata),
      .data_scsucceed (data_scsucceed)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   // power-on contents of the memory model with a distinct value per byte address
   function automatic word_t initial_word(input int idx);
      logic [7:0] ba;
      ba = 8'(idx << 2);
      return {ba ^ 8'h5a, ba ^ 8'hc3, ~ba, ba};
   endfunction

   function automatic word_t load_value(input word_t w, input lsu_op_t op, input byte_off_t off);
      word_t lane;
      lane = w >> (8 * off);
      case (op)
         LSU_LD_B:  return {{24{lane[7]}}, lane[7:0]};
         LSU_LD_BU: return {24'd0, lane[7:0]};
         LSU_LD_H:  return {{16{lane[15]}}, lane[15:0]};
         LSU_LD_HU: return {16'd0, lane[15:0]};
         default:   return w;
      endcase
   endfunction

   task automatic run_operation(input lsu_op_t op, input logic [5:0] idx, input byte_off_t off);
      word_t addr;
      word_t ofs;
      word_t data;
      logic  is_store;
      logic  sc_ok;
      int    n;
      addr     = {24'd0, idx, off};
      ofs      = random_bits(12);
      ofs      = {{20{ofs[11]}}, ofs[11:0]};
      data     = random_bits(32);
      is_store = op inside {LSU_ST_B, LSU_ST_H, LSU_ST_W};
      @(negedge clk);
      valid         = 1'b1;
      lsu_op        = op;
      offset        = ofs;
      base          = addr - ofs;
      wdata         = data;
      ecl_lsu_rd_e  = REG_ADDR_W'(random_bits(REG_ADDR_W));
      ecl_lsu_wen_e = random_bits(1) != 0;
      accept_delay  = 2'(random_bits(2));
      return_delay  = 2'(random_bits(2));
      exp_rd        = ecl_lsu_rd_e;
      exp_wen       = ecl_lsu_wen_e;
      exp_addr      = addr;
      exp_ctrl      = {is_store || op == LSU_SC_W, op == LSU_LL_W, op == LSU_SC_W};
      case (op)
         LSU_ST_B: begin
            exp_wstrb = 4'b0001 << off;
            exp_wdata = {4{data[7:0]}};
         end
         LSU_ST_H: begin
            exp_wstrb = 4'b0011 << off;
            exp_wdata = {2{data[15:0]}};
         end
         default: begin
            exp_wstrb = 4'hf;
            exp_wdata = data;
         end
      endcase
      sc_ok            = shadow_resv_valid && (shadow_resv_idx == idx);
      exp_check_result = !is_store;
      exp_result       = (op == LSU_SC_W) ? {31'd0, sc_ok} : load_value(shadow[idx], op, off);
      if (is_store || (op == LSU_SC_W && sc_ok)) begin
         for (int i = 0; i < 4; i++) begin
            if (exp_wstrb[i])
               shadow[idx][8*i +: 8] = exp_wdata[8*i +: 8];
         end
      end
      if (op == LSU_LL_W) begin
         shadow_resv_valid = 1'b1;
         shadow_resv_idx   = idx;
      end else if (op == LSU_SC_W || (is_store && idx == shadow_resv_idx)) begin
         shadow_resv_valid = 1'b0;
      end
      n = 0;
      while (!data_addr_ok && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!data_addr_ok)
         abort_run("timeout: memory never accepted the request");
      // hold valid through the accepting edge
      @(negedge clk);
      valid = 1'b0;
      n = 0;
      while (!data_data_ok && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!data_data_ok)
         abort_run("timeout: memory never returned data");
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         outstanding <= 1'b0;
      else if (data_addr_ok)
         outstanding <= 1'b1;
      else if (data_data_ok)
         outstanding <= 1'b0;
   end

   a_request: assert property (@(posedge clk) disable iff (!rst_n)
      data_req == valid)
      else abort_run($sformatf("FAIL data_req got 0x%h expected 0x%h",
                               $sampled(data_req), $sampled(valid)));

   a_address: assert property (@(posedge clk) disable iff (!rst_n)
      valid |-> data_addr == exp_addr)
      else abort_run($sformatf("FAIL data_addr got 0x%h expected 0x%h",
                               $sampled(data_addr), $sampled(exp_addr)));

   a_store_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req && data_wr) |-> data_wstrb == exp_wstrb)
      else abort_run($sformatf("FAIL data_wstrb got 0x%h expected 0x%h",
                               $sampled(data_wstrb), $sampled(exp_wstrb)));

   a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req && data_wr) |-> data_wdata == exp_wdata)
      else abort_run($sformatf("FAIL data_wdata got 0x%h expected 0x%h",
                               $sampled(data_wdata), $sampled(exp_wdata)));

   a_control: assert property (@(posedge clk) disable iff (!rst_n)
      data_req |-> {data_wr, data_ll, data_sc} == exp_ctrl)
      else abort_run($sformatf("FAIL data_wr/data_ll/data_sc got 0x%h expected 0x%h",
                               $sampled({data_wr, data_ll, data_sc}), $sampled(exp_ctrl)));

   a_result: assert property (@(posedge clk) disable iff (!rst_n)
      (data_data_ok && exp_check_result) |-> read_result_m == exp_result)
      else abort_run($sformatf("FAIL read_result_m got 0x%h expected 0x%h",
                               $sampled(read_result_m), $sampled(exp_result)));

   a_recv: assert property (@(posedge clk) disable iff (!rst_n)
      data_recv == outstanding)
      else abort_run($sformatf("FAIL data_recv got 0x%h expected 0x%h",
                               $sampled(data_recv), $sampled(outstanding)));

   a_dest: assert property (@(posedge clk) disable iff (!rst_n)
      data_data_ok |-> lsu_ecl_rd_m == exp_rd && lsu_ecl_wen_m == exp_wen)
      else abort_run($sformatf("FAIL lsu_ecl_rd_m/wen_m got 0x%h/0x%h expected 0x%h/0x%h",
                               $sampled(lsu_ecl_rd_m), $sampled(lsu_ecl_wen_m),
                               $sampled(exp_rd), $sampled(exp_wen)));

   a_rdata_valid: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_rdata_valid_m == data_data_ok)
      else abort_run($sformatf("FAIL lsu_rdata_valid_m got 0x%h expected 0x%h",
                               $sampled(lsu_rdata_valid_m), $sampled(data_data_ok)));

   initial begin
      lsu_op_t    op;
      lsu_op_t    prev_op;
      logic [5:0] idx;
      logic [5:0] prev_idx;
      logic [5:0] ll_idx;
      byte_off_t  off;
      lfsr              = 32'd85308;
      rst_n             = 1'b0;
      valid             = 1'b0;
      lsu_op            = LSU_LD_W;
      base              = '0;
      offset            = '0;
      wdata             = '0;
      ecl_lsu_rd_e      = '0;
      ecl_lsu_wen_e     = 1'b0;
      accept_delay      = '0;
      return_delay      = '0;
      exp_addr          = '0;
      exp_ctrl          = '0;
      exp_wstrb         = '0;
      exp_wdata         = '0;
      exp_result        = '0;
      exp_check_result  = 1'b0;
      exp_rd            = '0;
      exp_wen           = 1'b0;
      shadow_resv_valid = 1'b0;
      shadow_resv_idx   = '0;
      prev_op           = LSU_LD_W;
      prev_idx          = '0;
      ll_idx            = '0;
      for (int i = 0; i < 64; i++)
         shadow[i] = initial_word(i);
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int k = 0; k < NUM_OPS; k++) begin
         if (prev_op == LSU_SC_W) begin
            // read back the word the sc targeted
            op  = LSU_LD_W;
            idx = prev_idx;
         end else begin
            op  = OP_LIST[random_bits(4) % 10];
            idx = 6'(random_bits(6));
            if (op == LSU_SC_W && random_bits(1) != 0)
               idx = ll_idx;
         end
         case (op)
            LSU_LD_B, LSU_LD_BU, LSU_ST_B: off = byte_off_t'(random_bits(2));
            LSU_LD_H, LSU_LD_HU, LSU_ST_H: off = byte_off_t'(random_bits(1) << 1);
            default:                       off = 2'b00;
         endcase
         if (op == LSU_LL_W)
            ll_idx = idx;
         run_operation(op, idx, off);
         prev_op  = op;
         prev_idx = idx;
      end
      @(negedge clk);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
design/lsu_pkg.sv
design/lsu_issue.sv
design/lsu_mem_track.sv
design/lsu_load_align.sv
design/lsu_top.sv
verif/lsu_mem_model.sv
verif/tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - design/lsu_pkg.sv
      - design/lsu_issue.sv
      - design/lsu_mem_track.sv
      - design/lsu_load_align.sv
      - design/lsu_top.sv
  - target: test
    files:
      - verif/lsu_mem_model.sv
      - verif/tb_lsu.sv
